// File: rtl/alu.sv
`timescale 1ns/100ps

module alu (
    input  cpuPkg::wordT  regA,
    input  cpuPkg::wordT  regB,
    input  cpuPkg::aluOpE aluOp,
    output cpuPkg::wordT  aluResult
);
    import cpuPkg::*;

    // Purely combinational, result settles in the same cycle as the opcode
    always_comb begin
        case (aluOp)
            add:  aluResult = regA + regB;
            sub:  aluResult = regA - regB;
            // Low byte of the product only
            mul:  aluResult = regA * regB;
            // Single-bit logical shifts of A
            shlA: aluResult = regA << 1;
            shrA: aluResult = regA >> 1;
            incA: aluResult = regA + 8'd1;
            incB: aluResult = regB + 8'd1;
            decA: aluResult = regA - 8'd1;
            decB: aluResult = regB - 8'd1;
            // Compares return 1 or 0, bit 0 drives the branch decision
            eq:   aluResult = {7'd0, regA == regB};
            gt:   aluResult = {7'd0, regA > regB};
            lt:   aluResult = {7'd0, regA < regB};
            // Reserved functions
            default: aluResult = '0;
        endcase
    end

endmodule

// File: rtl/busPkg.sv
package busPkg;

    // Registered request towards data memory, 17 bits
    typedef struct packed {
        cpuPkg::wordT addr;
        cpuPkg::wordT data;
        // High for exactly one cycle per store
        logic         we;
    } busReqS;

    // One bit per interrupt line, bit 0 has priority
    typedef logic [1:0] irqT;

endpackage

// File: rtl/cpuPkg.sv
package cpuPkg;

    // Data and address word
    typedef logic [7:0] wordT;

    // Instruction code in the low nibble of the instruction byte
    // Codes D to F are reserved and leave the FSM in decode
    typedef enum logic [3:0] {
        readA    = 4'h0,
        readB    = 4'h1,
        writeA   = 4'h2,
        writeB   = 4'h3,
        mathsA   = 4'h4,
        mathsB   = 4'h5,
        branch   = 4'h6,
        gotoAddr = 4'h7,
        idle     = 4'h8,
        call     = 4'h9,
        ret      = 4'hA,
        derefA   = 4'hB,
        derefB   = 4'hC
    } opcodeE;

    // ALU function in the high nibble, codes C to F give zero
    typedef enum logic [3:0] {
        add  = 4'h0,
        sub  = 4'h1,
        mul  = 4'h2,
        shlA = 4'h3,
        shrA = 4'h4,
        incA = 4'h5,
        incB = 4'h6,
        decA = 4'h7,
        decB = 4'h8,
        eq   = 4'h9,
        gt   = 4'hA,
        lt   = 4'hB
    } aluOpE;

    // Program counter action for the next edge
    typedef enum logic [2:0] {
        hold,
        step1,
        step2,
        loadRom,
        loadContext,
        loadVector
    } pcOpE;

    // Source of the next bus address
    typedef enum logic [1:0] {
        srcIdle,
        srcRom,
        srcRegA,
        srcRegB
    } addrSrcE;

    // Sequencer to program counter, 7 bits
    typedef struct packed {
        pcOpE       pcOp;
        logic [1:0] fetchOffset;
        logic       saveContext;
        // Low picks interrupt A vector
        logic       vectorSel;
    } pcCtrlS;

    // Sequencer to data path, 7 bits
    typedef struct packed {
        logic    regSel;
        logic    setRegSel;
        logic    loadFromBus;
        logic    loadFromAlu;
        addrSrcE addrSrc;
        logic    write;
    } dpCtrlS;

endpackage

// File: rtl/dataPath.sv
`timescale 1ns/100ps

module dataPath #(
    parameter cpuPkg::wordT idleAddr = 8'hFF
) (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::dpCtrlS dpCtrl,
    input  cpuPkg::wordT   romData,
    input  cpuPkg::wordT   busRdData,
    input  cpuPkg::wordT   aluResult,
    output cpuPkg::wordT   regA,
    output cpuPkg::wordT   regB,
    output busPkg::busReqS busReq
);
    import cpuPkg::*;

    // Register select for memory loads and stores, 0 is A
    logic regSel;
    wordT selData;

    // Registered bus request fields
    wordT busAddr;
    wordT busData;
    logic busWe;

    assign selData = regSel ? regB : regA;

    //////////////////////////////////////////////////
    // Register file

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA   <= '0;
            regB   <= '0;
            regSel <= 1'b0;
        end else begin
            if (dpCtrl.setRegSel) begin
                regSel <= dpCtrl.regSel;
            end
            // Memory data goes to the stored select
            if (dpCtrl.loadFromBus) begin
                if (regSel) begin
                    regB <= busRdData;
                end else begin
                    regA <= busRdData;
                end
            // ALU result goes to the select given this cycle
            end else if (dpCtrl.loadFromAlu) begin
                if (dpCtrl.regSel) begin
                    regB <= aluResult;
                end else begin
                    regA <= aluResult;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Bus request, one cycle behind the control

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= idleAddr;
            busWe   <= 1'b0;
        end else begin
            busWe <= dpCtrl.write;
            case (dpCtrl.addrSrc)
                srcRom:  busAddr <= romData;
                srcRegA: busAddr <= regA;
                srcRegB: busAddr <= regB;
                // Park the address when nothing is accessed
                default: busAddr <= idleAddr;
            endcase
        end
    end

    // Store data follows the selected register, only qualified by we
    always_ff @(posedge CLK) begin
        busData <= selData;
    end

    assign busReq = '{addr: busAddr, data: busData, we: busWe};

endmodule

// File: rtl/processorTop.sv
`timescale 1ns/100ps

module processorTop #(
    // ROM slots that hold the handler start addresses
    parameter cpuPkg::wordT irqVectorA = 8'hFF,
    parameter cpuPkg::wordT irqVectorB = 8'hFE,
    // Bus address while nothing is accessed
    parameter cpuPkg::wordT idleAddr   = 8'hFF
) (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::wordT   romData,
    input  cpuPkg::wordT   busRdData,
    input  busPkg::irqT    irqRaise,
    output cpuPkg::wordT   romAddr,
    output busPkg::busReqS busReq,
    output busPkg::irqT    irqAck
);
    import cpuPkg::*;

    wordT   regA;
    wordT   regB;
    wordT   aluResult;
    aluOpE  aluOp;
    pcCtrlS pcCtrl;
    dpCtrlS dpCtrl;

    // Shared by maths and branch compare
    alu alu_i (
        .regA      (regA),
        .regB      (regB),
        .aluOp     (aluOp),
        .aluResult (aluResult)
    );

    programCounter #(
        .irqVectorA (irqVectorA),
        .irqVectorB (irqVectorB)
    ) programCounter_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .pcCtrl  (pcCtrl),
        .romData (romData),
        .romAddr (romAddr)
    );

    dataPath #(
        .idleAddr (idleAddr)
    ) dataPath_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .dpCtrl    (dpCtrl),
        .romData   (romData),
        .busRdData (busRdData),
        .aluResult (aluResult),
        .regA      (regA),
        .regB      (regB),
        .busReq    (busReq)
    );

    sequencer sequencer_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .aluResult (aluResult),
        .irqRaise  (irqRaise),
        .pcCtrl    (pcCtrl),
        .dpCtrl    (dpCtrl),
        .aluOp     (aluOp),
        .irqAck    (irqAck)
    );

endmodule

// File: rtl/programCounter.sv
`timescale 1ns/100ps

module programCounter #(
    parameter cpuPkg::wordT irqVectorA = 8'hFF,
    parameter cpuPkg::wordT irqVectorB = 8'hFE
) (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::pcCtrlS pcCtrl,
    input  cpuPkg::wordT   romData,
    output cpuPkg::wordT   romAddr
);
    import cpuPkg::*;

    wordT       pc;
    logic [1:0] fetchOffset;
    // Single level of call nesting
    wordT       returnAddr;

    //////////////////////////////////////////////////
    // Counter, offset and return context

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc          <= '0;
            fetchOffset <= '0;
            returnAddr  <= '0;
        end else begin
            // Offset only lives for one cycle unless renewed
            fetchOffset <= pcCtrl.fetchOffset;

            // Skip over the call opcode and its target byte
            if (pcCtrl.saveContext) begin
                returnAddr <= pc + 8'd2;
            end

            case (pcCtrl.pcOp)
                step1:       pc <= pc + 8'd1;
                step2:       pc <= pc + 8'd2;
                // Jump target is the operand byte on the ROM port
                loadRom:     pc <= romData;
                loadContext: pc <= returnAddr;
                // Vector slot address, the handler address is fetched from it later
                loadVector:  pc <= pcCtrl.vectorSel ? irqVectorB : irqVectorA;
                default:     pc <= pc;
            endcase
        end
    end

    // Offset lets the sequencer peek at the operand without moving pc
    assign romAddr = pc + {6'd0, fetchOffset};

endmodule

// File: rtl/sequencer.sv
`timescale 1ns/100ps

module sequencer (
    input  logic           CLK,
    input  logic           RESET,
    input  cpuPkg::wordT   romData,
    input  cpuPkg::wordT   aluResult,
    input  busPkg::irqT    irqRaise,
    output cpuPkg::pcCtrlS pcCtrl,
    output cpuPkg::dpCtrlS dpCtrl,
    output cpuPkg::aluOpE  aluOp,
    output busPkg::irqT    irqAck
);
    import cpuPkg::*;
    import busPkg::*;

    // One chain of states per instruction group
    typedef enum logic [4:0] {
        sIdle, sThread0, sThread1, sThread2,
        sDecode,
        sReadA, sReadB, sRead0, sRead1, sRead2,
        sWriteA, sWriteB, sWrite0,
        sMathsA, sMathsB, sMaths0,
        sBranch, sBranch0, sBranch1,
        sGoto, sGoto0, sGoto1,
        sCall, sCall0, sCall1,
        sRet, sRet0,
        sDerefA, sDerefB, sDeref0, sDeref1
    } stateE;

    stateE state;
    stateE stateNext;
    irqT   ackNext;

    // High nibble of the instruction byte, valid in the first step state
    assign aluOp = aluOpE'(romData[7:4]);

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state  <= sDecode;
            irqAck <= '0;
        end else begin
            state  <= stateNext;
            irqAck <= ackNext;
        end
    end

    always_comb begin
        // Defaults, each state overrides only what it needs
        stateNext = state;
        ackNext   = '0;
        pcCtrl    = '{pcOp: hold, fetchOffset: 2'd0, saveContext: 1'b0, vectorSel: 1'b0};
        dpCtrl    = '{regSel: 1'b0, setRegSel: 1'b0, loadFromBus: 1'b0,
                      loadFromAlu: 1'b0, addrSrc: srcIdle, write: 1'b0};

        case (state)
            //////////////////////////////////////////////////
            // Thread start on interrupt
            sIdle: begin
                // Line 0 wins when both are raised
                if (irqRaise[0]) begin
                    stateNext        = sThread0;
                    pcCtrl.pcOp      = loadVector;
                    ackNext          = 2'b01;
                end else if (irqRaise[1]) begin
                    stateNext        = sThread0;
                    pcCtrl.pcOp      = loadVector;
                    pcCtrl.vectorSel = 1'b1;
                    ackNext          = 2'b10;
                end
            end
            // ROM latency for the vector slot
            sThread0: stateNext = sThread1;
            // Handler address now on romData
            sThread1: begin
                stateNext   = sThread2;
                pcCtrl.pcOp = loadRom;
            end
            sThread2: stateNext = sDecode;

            //////////////////////////////////////////////////
            // Decode
            sDecode: begin
                case (opcodeE'(romData[3:0]))
                    readA:    stateNext = sReadA;
                    readB:    stateNext = sReadB;
                    writeA:   stateNext = sWriteA;
                    writeB:   stateNext = sWriteB;
                    mathsA:   stateNext = sMathsA;
                    mathsB:   stateNext = sMathsB;
                    branch:   stateNext = sBranch;
                    gotoAddr: stateNext = sGoto;
                    idle:     stateNext = sIdle;
                    call:     stateNext = sCall;
                    ret:      stateNext = sRet;
                    derefA:   stateNext = sDerefA;
                    derefB:   stateNext = sDerefB;
                    // Reserved code, stuck here
                    default:  stateNext = sDecode;
                endcase
                // Point the ROM at the operand byte
                pcCtrl.fetchOffset = 2'd1;
            end

            //////////////////////////////////////////////////
            // Memory read, operand is the address
            sReadA, sReadB: begin
                stateNext        = sRead0;
                dpCtrl.setRegSel = 1'b1;
                dpCtrl.regSel    = (state == sReadB);
            end
            sRead0: begin
                stateNext      = sRead1;
                dpCtrl.addrSrc = srcRom;
            end
            // Step two cycles early so the next opcode is ready at decode
            sRead1: begin
                stateNext   = sRead2;
                pcCtrl.pcOp = step2;
            end
            sRead2: begin
                stateNext          = sDecode;
                dpCtrl.loadFromBus = 1'b1;
            end

            // Memory write, store is on the bus during the next decode
            sWriteA, sWriteB: begin
                stateNext        = sWrite0;
                dpCtrl.setRegSel = 1'b1;
                dpCtrl.regSel    = (state == sWriteB);
                pcCtrl.pcOp      = step2;
            end
            sWrite0: begin
                stateNext      = sDecode;
                dpCtrl.addrSrc = srcRom;
                dpCtrl.write   = 1'b1;
            end

            //////////////////////////////////////////////////
            // ALU result straight into A or B
            sMathsA, sMathsB: begin
                stateNext          = sMaths0;
                dpCtrl.loadFromAlu = 1'b1;
                dpCtrl.regSel      = (state == sMathsB);
                pcCtrl.pcOp        = step1;
            end
            sMaths0: stateNext = sDecode;

            // Conditional branch on ALU bit 0
            sBranch: begin
                if (aluResult[0]) begin
                    stateNext   = sBranch0;
                end else begin
                    stateNext   = sBranch1;
                    pcCtrl.pcOp = step2;
                end
            end
            sBranch0: begin
                stateNext   = sBranch1;
                pcCtrl.pcOp = loadRom;
            end
            sBranch1: stateNext = sDecode;

            // Unconditional jump
            sGoto: stateNext = sGoto0;
            sGoto0: begin
                stateNext   = sGoto1;
                pcCtrl.pcOp = loadRom;
            end
            sGoto1: stateNext = sDecode;

            // Call saves pc + 2, then jumps like goto
            sCall: begin
                stateNext          = sCall0;
                pcCtrl.saveContext = 1'b1;
            end
            sCall0: begin
                stateNext   = sCall1;
                pcCtrl.pcOp = loadRom;
            end
            sCall1: stateNext = sDecode;

            sRet: begin
                stateNext   = sRet0;
                pcCtrl.pcOp = loadContext;
            end
            sRet0: stateNext = sDecode;

            //////////////////////////////////////////////////
            // Dereference, register holds the address
            sDerefA, sDerefB: begin
                stateNext        = sDeref0;
                dpCtrl.setRegSel = 1'b1;
                dpCtrl.regSel    = (state == sDerefB);
                dpCtrl.addrSrc   = (state == sDerefB) ? srcRegB : srcRegA;
            end
            sDeref0: begin
                stateNext   = sDeref1;
                pcCtrl.pcOp = step1;
            end
            sDeref1: begin
                stateNext          = sDecode;
                dpCtrl.loadFromBus = 1'b1;
            end

            default: stateNext = sDecode;
        endcase
    end

endmodule

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps --top-module tbTop -f tinyCpu.f -o simTinyCpu

output=$(./obj_dir/simTinyCpu)
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

// File: testbench/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// Model copy of data memory and the architectural registers
logic [7:0] modelMem [256];
logic [7:0] modelA;
logic [7:0] modelB;
logic [7:0] modelRet;

//////////////////////////////////////////////////
// Random program generator

// Uniform pick in 0 to n-1 from the shared seed
function automatic int randBelow(input int n);
    randBelow = {$random(seed)} % n;
endfunction

// Two-byte instructions carry an operand byte
function automatic bit isLong(input logic [3:0] op);
    case (op)
        readA, readB, writeA, writeB, branch, gotoAddr, call: isLong = 1'b1;
        default: isLong = 1'b0;
    endcase
endfunction

// Subroutine body avoids control flow, writes and maths weighted up
function automatic logic [3:0] pickOp(input bit isSub);
    int k;
    k = isSub ? randBelow(8) : randBelow(14);
    if (isSub && k >= 6) begin
        k = k + 3;
    end
    case (k)
        0:       pickOp = readA;
        1:       pickOp = readB;
        2:       pickOp = writeA;
        3:       pickOp = writeB;
        4:       pickOp = mathsA;
        5:       pickOp = mathsB;
        6:       pickOp = branch;
        7:       pickOp = gotoAddr;
        8:       pickOp = call;
        9:       pickOp = derefA;
        10:      pickOp = derefB;
        11:      pickOp = writeA;
        12:      pickOp = writeB;
        default: pickOp = mathsB;
    endcase
endfunction

task automatic genRoutine(input wordT start, input int count, input bit isSub);
    logic [3:0] op [64];
    wordT       at [64];
    logic [3:0] nib;
    wordT       target;
    int         i;
    // First pass picks opcodes and lays out addresses
    at[0] = start;
    for (i = 0; i < count; i++) begin
        if (i == count - 1) begin
            op[6'(i)] = isSub ? ret : idle;
        end else begin
            op[6'(i)] = pickOp(isSub);
        end
        at[6'(i + 1)] = at[6'(i)] + (isLong(op[6'(i)]) ? 8'd2 : 8'd1);
    end
    // Second pass fills bytes, jumps land on a later instruction
    for (i = 0; i < count; i++) begin
        nib = 4'(randBelow(16));
        romImage[at[6'(i)]] = {nib, op[6'(i)]};
        case (op[6'(i)])
            branch, gotoAddr: target = at[6'(i + 1 + randBelow(count - 1 - i))];
            call:             target = subStart;
            default:          target = 8'(randBelow(256));
        endcase
        if (isLong(op[6'(i)])) begin
            romImage[at[6'(i)] + 8'd1] = target;
        end
    end
endtask

task automatic buildProgram();
    int i;
    // Unused ROM reads as idle
    for (i = 0; i < 256; i++) begin
        romImage[8'(i)] = 8'h08;
    end
    genRoutine(mainStart, mainLen, 1'b0);
    genRoutine(subStart, subLen, 1'b1);
    genRoutine(handlerAStart, handlerLen, 1'b0);
    genRoutine(handlerBStart, handlerLen, 1'b0);
    romImage[vecSlotA] = handlerAStart;
    romImage[vecSlotB] = handlerBStart;
    for (i = 0; i < 256; i++) begin
        dataMem[8'(i)]  = 8'(randBelow(256));
        modelMem[8'(i)] = dataMem[8'(i)];
    end
    modelA   = 8'h00;
    modelB   = 8'h00;
    modelRet = 8'h00;
endtask

//////////////////////////////////////////////////
// Instruction-level reference

// Arithmetic in int, result wraps to the low byte
function automatic wordT aluRef(input logic [3:0] fn, input int a, input int b);
    int wide;
    case (fn)
        4'h0:    wide = a + b;
        4'h1:    wide = a - b;
        4'h2:    wide = a * b;
        4'h3:    wide = a * 2;
        4'h4:    wide = a / 2;
        4'h5:    wide = a + 1;
        4'h6:    wide = b + 1;
        4'h7:    wide = a - 1;
        4'h8:    wide = b - 1;
        4'h9:    wide = (a == b) ? 1 : 0;
        4'hA:    wide = (a > b) ? 1 : 0;
        4'hB:    wide = (a < b) ? 1 : 0;
        default: wide = 0;
    endcase
    aluRef = wide[7:0];
endfunction

// Runs one routine up to its idle, queueing every store
task automatic runRoutine(input wordT start);
    wordT   pc;
    wordT   ins;
    wordT   opd;
    wordT   res;
    int     steps;
    bit     done;
    busReqS st;
    pc    = start;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000) begin
        ins   = romImage[pc];
        opd   = romImage[pc + 8'd1];
        res   = aluRef(ins[7:4], int'(modelA), int'(modelB));
        steps = steps + 1;
        case (ins[3:0])
            4'h0: begin
                modelA = modelMem[opd];
                pc     = pc + 8'd2;
            end
            4'h1: begin
                modelB = modelMem[opd];
                pc     = pc + 8'd2;
            end
            4'h2, 4'h3: begin
                st = '{addr: opd, data: ins[0] ? modelB : modelA, we: 1'b1};
                expStores.push_back(st);
                modelMem[opd] = st.data;
                pc            = pc + 8'd2;
            end
            4'h4: begin
                modelA = res;
                pc     = pc + 8'd1;
            end
            4'h5: begin
                modelB = res;
                pc     = pc + 8'd1;
            end
            // Branch taken on bit 0 of the compare
            4'h6:    pc = res[0] ? opd : pc + 8'd2;
            4'h7:    pc = opd;
            4'h9: begin
                modelRet = pc + 8'd2;
                pc       = opd;
            end
            4'hA:    pc = modelRet;
            4'hB: begin
                modelA = modelMem[modelA];
                pc     = pc + 8'd1;
            end
            4'hC: begin
                modelB = modelMem[modelB];
                pc     = pc + 8'd1;
            end
            default: done = 1'b1;
        endcase
    end
endtask

// Main first, then one handler per raise in priority order
task automatic buildExpected();
    int  k;
    irqT raise;
    runRoutine(mainStart);
    for (k = 0; k < 3; k++) begin
        raise = raiseSeq[2'(k)];
        if (raise[0]) begin
            expAcks.push_back(2'b01);
            runRoutine(romImage[vecSlotA]);
        end else begin
            expAcks.push_back(2'b10);
            runRoutine(romImage[vecSlotB]);
        end
    end
endtask

`endif

// File: testbench/tbTop.sv
`timescale 1ns/100ps

module tbTop;
    import cpuPkg::*;
    import busPkg::*;

    localparam int   clkPeriod     = 40;
    localparam int   resetCycles   = 16;
    localparam int   settleCycles  = 100;
    localparam wordT vecSlotA      = 8'hFF;
    localparam wordT vecSlotB      = 8'hFE;
    localparam wordT parkAddr      = 8'hFF;
    // ROM layout of the generated routines
    localparam wordT mainStart     = 8'h00;
    localparam wordT subStart      = 8'h40;
    localparam wordT handlerAStart = 8'h60;
    localparam wordT handlerBStart = 8'hA0;
    localparam int   mainLen       = 24;
    localparam int   subLen        = 7;
    localparam int   handlerLen    = 14;
    localparam int   totalInstrs   = mainLen + subLen + 2 * handlerLen;

    logic   CLK;
    logic   RESET;
    wordT   romData;
    wordT   busRdData;
    irqT    irqRaise;
    wordT   romAddr;
    busReqS busReq;
    irqT    irqAck;

    wordT   romImage [256];
    wordT   dataMem [256];
    integer seed;
    busReqS expStores [$];
    irqT    expAcks [$];
    irqT    raiseSeq [3];
    int     storeErrors;
    int     ackErrors;
    int     flowErrors;
    int     ackCount;
    irqT    lastAck;

    `include "tbIsaModel.svh"

    always #(clkPeriod / 2) CLK = ~CLK;

    processorTop #(
        .irqVectorA (vecSlotA),
        .irqVectorB (vecSlotB),
        .idleAddr   (parkAddr)
    ) dut_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .romData   (romData),
        .busRdData (busRdData),
        .irqRaise  (irqRaise),
        .romAddr   (romAddr),
        .busReq    (busReq),
        .irqAck    (irqAck)
    );

    //////////////////////////////////////////////////
    // ROM and data memory with one cycle of latency

    always @(posedge CLK) begin
        romData   <= romImage[romAddr];
        busRdData <= dataMem[busReq.addr];
        if (busReq.we) begin
            dataMem[busReq.addr] <= busReq.data;
        end
    end

    // Each raise is held until its acknowledge, then the next one follows
    always @(posedge CLK) begin
        if (ackCount < 3) begin
            irqRaise <= raiseSeq[2'(ackCount)];
        end else begin
            irqRaise <= '0;
        end
    end

    //////////////////////////////////////////////////
    // Checks

    task automatic checkStore(input busReqS expected, input busReqS actual);
        if (actual !== expected) begin
            storeErrors++;
            $display("ERROR %0t busReq expected addr=%h data=%h we=%b actual addr=%h data=%h we=%b",
                     $time, expected.addr, expected.data, expected.we,
                     actual.addr, actual.data, actual.we);
        end
    endtask

    task automatic checkAck(input irqT expected, input irqT actual);
        if (actual !== expected) begin
            ackErrors++;
            $display("ERROR %0t irqAck expected %b actual %b", $time, expected, actual);
        end
    endtask

    task automatic printCounts();
        $display("Errors: store %0d, acknowledge %0d, other %0d",
                 storeErrors, ackErrors, flowErrors);
    endtask

    // Store and acknowledge monitor against the model queues
    always @(negedge CLK) begin
        busReqS wantStore;
        irqT    wantAck;
        if (!RESET) begin
            if (busReq.we) begin
                if (expStores.size() == 0) begin
                    flowErrors++;
                    $display("Extra store at %0t to address %h not predicted by the model",
                             $time, busReq.addr);
                end else begin
                    wantStore = expStores.pop_front();
                    checkStore(wantStore, busReq);
                end
            end
            if (irqAck != '0) begin
                // A second high cycle is a stretched pulse rather than a new acknowledge
                if (lastAck != '0) begin
                    flowErrors++;
                    $display("Acknowledge at %0t stayed high for more than one cycle", $time);
                end else if (expAcks.size() == 0) begin
                    flowErrors++;
                    $display("Extra acknowledge at %0t not predicted by the model", $time);
                    ackCount++;
                end else begin
                    wantAck = expAcks.pop_front();
                    checkAck(wantAck, irqAck);
                    ackCount++;
                end
            end
            lastAck = irqAck;
        end
    end

    //////////////////////////////////////////////////
    // Run control

    initial begin
        CLK         = 1'b0;
        RESET       = 1'b1;
        romData     = '0;
        busRdData   = '0;
        irqRaise    = '0;
        seed        = 32'h15d5_4638;
        storeErrors = 0;
        ackErrors   = 0;
        flowErrors  = 0;
        ackCount    = 0;
        lastAck     = '0;
        // Line 1 alone, line 0 alone, then both together
        raiseSeq[0] = 2'b10;
        raiseSeq[1] = 2'b01;
        raiseSeq[2] = 2'b11;
        buildProgram();
        buildExpected();

        repeat (resetCycles) @(posedge CLK);
        RESET <= 1'b0;

        while (expStores.size() != 0 || ackCount < 3) begin
            @(negedge CLK);
        end
        // Window for stores past the last predicted one
        repeat (settleCycles) @(negedge CLK);

        printCounts();
        if (storeErrors + ackErrors + flowErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Budget of 20 cycles per generated instruction
    initial begin
        #(20 * totalInstrs * clkPeriod);
        $display("Timeout at %0t with %0d stores and %0d acknowledges still missing",
                 $time, expStores.size(), expAcks.size());
        printCounts();
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: tinyCpu.f
+incdir+testbench
rtl/cpuPkg.sv
rtl/busPkg.sv
rtl/alu.sv
rtl/programCounter.sv
rtl/dataPath.sv
rtl/sequencer.sv
rtl/processorTop.sv
testbench/tbTop.sv
